// File: verilog/fetch_pkg.sv
// fetch address type, reset vector and redirect sources shared by the fetch predictor

package fetch_pkg;

  // ==================================================
  // fetch address
  // ==================================================

  localparam int PC_WIDTH = 32;                   // one word per fetch address

  typedef logic [PC_WIDTH-1:0] pc_addr_t;

  // where fetch starts after reset
  localparam pc_addr_t RST_PC = 32'hFFFC_0000;

  // four instructions of six bytes each per fetch group
  localparam pc_addr_t FETCH_BYTES = 32'd24;

  // ==================================================
  // next-address sources
  // ==================================================

  // listed in priority order, highest first
  typedef enum logic [2:0] {
    redir_irq,                                    // interrupt vector
    redir_ret,                                    // return stack top
    redir_miss,                                   // branch-miss correction
    redir_btb,                                    // predicted taken target
    redir_seq                                     // fall through to the next group
  } redirect_t;

endpackage

// File: verilog/btb_pkg.sv
// BTB geometry, table entry layout and return-stack types for the fetch predictor

package btb_pkg;

  import fetch_pkg::*;

  // ==================================================
  // branch target buffer
  // ==================================================

  localparam int BTB_DEPTH   = 1024;              // one bank, one lookup per group
  localparam int BTB_IDX_BITS = $clog2(BTB_DEPTH);
  localparam int BTB_IDX_LSB  = 1;                // index is addr[10:1]

  typedef logic [BTB_IDX_BITS-1:0] btb_idx_t;

  typedef struct packed {
    logic     takb;                               // last commit was taken
    pc_addr_t tag;                                // full branch address
    pc_addr_t tgt;                                // branch target
  } btb_entry_t;

  // table slot for a fetch or commit address
  function automatic btb_idx_t btb_index(input pc_addr_t addr);
    return addr[BTB_IDX_LSB +: BTB_IDX_BITS];
  endfunction

  // ==================================================
  // return-address stack
  // ==================================================

  localparam int RAS_DEPTH = 16;

  typedef logic [$clog2(RAS_DEPTH)-1:0] ras_ptr_t;

  typedef enum logic [1:0] {
    ras_nop,
    ras_push,                                     // call
    ras_pop                                       // return
  } ras_op_t;

endpackage

// File: verilog/btb_ifs.sv
// internal buses of the fetch predictor, the BTB write port and the lookup path

`timescale 1ns/1ps

// commit stage -> table write port
interface btb_wr_if import btb_pkg::*; ();

  logic       wr_en;                              // one cycle per commit
  btb_idx_t   wr_idx;
  btb_entry_t wr_entry;

  modport src (
    output wr_en,
    output wr_idx,
    output wr_entry
  );

  modport dst (
    input wr_en,
    input wr_idx,
    input wr_entry
  );

endinterface

// pc select <-> lookup, index out and prediction back
interface btb_pred_if import fetch_pkg::*, btb_pkg::*; ();

  btb_idx_t rd_idx;                               // index of the pc being loaded
  pc_addr_t rd_pc;                                // current pc for the tag compare
  logic     hit;                                  // taken entry with matching tag
  pc_addr_t hit_tgt;

  modport sel (output rd_idx, output rd_pc, input hit, input hit_tgt);

  modport lkp (input rd_idx, input rd_pc, output hit, output hit_tgt);

endinterface

// File: verilog/btb_commit_stage.sv
// registers commit results and drives the BTB write port one cycle later

`timescale 1ns/1ps

module btb_commit_stage import fetch_pkg::*, btb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     commit_valid,                  // a branch retired this cycle
  input  pc_addr_t commit_pc,
  input  pc_addr_t commit_tgt,
  input  logic     commit_takb,                   // resolved direction
  btb_wr_if.src    wr
);

  // ==================================================
  // write enable
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      wr.wr_en <= 1'b0;
    end else begin
      wr.wr_en <= commit_valid;                   // pulse per commit, not sticky
    end
  end

  // ==================================================
  // entry and index
  // ==================================================

  // every commit is written, so a not-taken result
  // overwrites an older taken prediction
  always_ff @(posedge clk) begin
    wr.wr_idx        <= btb_index(commit_pc);
    wr.wr_entry.takb <= commit_takb;
    wr.wr_entry.tag  <= commit_pc;                // full address, no aliasing
    wr.wr_entry.tgt  <= commit_tgt;
  end

endmodule

// File: verilog/btb_lookup_stage.sv
// BTB table with registered read and the taken/tag compare for the current pc

`timescale 1ns/1ps

module btb_lookup_stage import btb_pkg::*; (
  input  logic  clk,
  btb_wr_if.dst wr,                               // from the commit stage
  btb_pred_if.lkp pred                            // to and from pc select
);

  // ==================================================
  // table storage
  // ==================================================

  // block RAM style, starts cleared so nothing predicts taken
  btb_entry_t btb_mem [BTB_DEPTH] = '{default: '0};

  btb_entry_t rd_q;                               // entry for the current pc

  // simple dual port, write a / read b on one clock
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      btb_mem[wr.wr_idx] <= wr.wr_entry;
    end
    rd_q <= btb_mem[pred.rd_idx];                 // old data on a same-edge write
  end

  // ==================================================
  // prediction compare
  // ==================================================

  // the read index followed the loaded pc, so rd_q lines up with rd_pc
  always_comb begin
    pred.hit     = rd_q.takb && (rd_q.tag == pred.rd_pc);
    pred.hit_tgt = rd_q.tgt;
  end

endmodule

// File: verilog/return_stack.sv
// circular return-address stack, pushed on calls and popped on returns

`timescale 1ns/1ps

module return_stack import fetch_pkg::*, btb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  ras_op_t  op,                            // already qualified by advance
  input  pc_addr_t push_addr,                     // return address of the call
  output pc_addr_t top
);

  // an underflow reads the reset vector or whatever was popped last
  pc_addr_t stack_mem [RAS_DEPTH] = '{default: RST_PC};

  ras_ptr_t sp;                                   // next free slot
  ras_ptr_t top_ptr;                              // newest entry, wraps below zero

  assign top_ptr = sp - 1'b1;
  assign top     = stack_mem[top_ptr];

  // ==================================================
  // push / pop
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
    end else begin
      case (op)
        ras_push: begin
          stack_mem[sp] <= push_addr;
          sp            <= sp + 1'b1;             // deep nesting overwrites oldest
        end
        ras_pop: begin
          sp <= top_ptr;                          // entry stays for a later underflow
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: verilog/pc_select_stage.sv
// priority next-address selection and the program counter register of the fetch predictor

`timescale 1ns/1ps

module pc_select_stage import fetch_pkg::*, btb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     advance,                       // global stall when low
  input  logic     irq,
  input  logic     do_call,
  input  logic     do_ret,
  input  logic     branchmiss,
  input  pc_addr_t irq_addr,
  input  pc_addr_t misspc,
  input  pc_addr_t ret_pc,                        // pushed on a call
  input  pc_addr_t ras_top,
  output ras_op_t  ras_op,
  btb_pred_if.sel  pred,
  output pc_addr_t pc,
  output pc_addr_t next_pc,
  output logic     takb
);

  redirect_t redir;                               // winning source this cycle

  // ==================================================
  // source priority
  // ==================================================

  always_comb begin
    if (irq) begin
      redir = redir_irq;
    end else if (do_ret) begin
      redir = redir_ret;
    end else if (branchmiss) begin
      redir = redir_miss;
    end else if (pred.hit) begin
      redir = redir_btb;                          // only when nothing else redirects
    end else begin
      redir = redir_seq;
    end
  end

  always_comb begin
    case (redir)
      redir_irq:  next_pc = irq_addr;
      redir_ret:  next_pc = ras_top;
      redir_miss: next_pc = misspc;
      redir_btb:  next_pc = pred.hit_tgt;
      default:    next_pc = pc + FETCH_BYTES;     // next fetch group
    endcase
  end

  assign takb = (redir == redir_btb);             // tells decode the branch was predicted

  // ==================================================
  // return stack control
  // ==================================================

  // call and return together cancel out
  always_comb begin
    ras_op = ras_nop;
    if (advance) begin
      if (do_call && !do_ret) begin
        ras_op = ras_push;
      end else if (do_ret && !do_call) begin
        ras_op = ras_pop;
      end
    end
  end

  // ==================================================
  // program counter and table read
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RST_PC;
    end else if (advance) begin
      pc <= next_pc;
    end
  end

  // index the value pc is about to load, so the registered
  // table read comes back in step with pc
  always_comb begin
    if (rst) begin
      pred.rd_idx = btb_index(RST_PC);
    end else if (advance) begin
      pred.rd_idx = btb_index(next_pc);
    end else begin
      pred.rd_idx = btb_index(pc);                // stalled, reread same slot
    end
  end

  assign pred.rd_pc = pc;

endmodule

// File: verilog/btb_fetch_top.sv
// top level of the fetch-address predictor, wires commit, lookup, return stack and pc select

`timescale 1ns/1ps

module btb_fetch_top import fetch_pkg::*, btb_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     advance,                       // stalls everything when low
  input  logic     irq,
  input  pc_addr_t irq_addr,
  input  logic     do_call,
  input  pc_addr_t ret_pc,
  input  logic     do_ret,
  input  logic     branchmiss,
  input  pc_addr_t misspc,
  input  logic     commit_valid,
  input  pc_addr_t commit_pc,
  input  logic     commit_takb,
  input  pc_addr_t commit_tgt,
  output pc_addr_t pc,
  output pc_addr_t next_pc,
  output logic     takb
);

  ras_op_t  ras_op;
  pc_addr_t ras_top;

  btb_wr_if   wr_bus ();                          // commit -> table
  btb_pred_if pred_bus ();                        // select <-> lookup

  // ==================================================
  // stages
  // ==================================================

  btb_commit_stage btb_commit_stage_i (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_tgt   (commit_tgt),
    .commit_takb  (commit_takb),
    .wr           (wr_bus.src)
  );

  btb_lookup_stage btb_lookup_stage_i (
    .clk  (clk),
    .wr   (wr_bus.dst),
    .pred (pred_bus.lkp)
  );

  return_stack return_stack_i (
    .clk       (clk),
    .rst       (rst),
    .op        (ras_op),
    .push_addr (ret_pc),
    .top       (ras_top)
  );

  pc_select_stage pc_select_stage_i (
    .clk        (clk),
    .rst        (rst),
    .advance    (advance),
    .irq        (irq),
    .do_call    (do_call),
    .do_ret     (do_ret),
    .branchmiss (branchmiss),
    .irq_addr   (irq_addr),
    .misspc     (misspc),
    .ret_pc     (ret_pc),
    .ras_top    (ras_top),
    .ras_op     (ras_op),
    .pred       (pred_bus.sel),
    .pc         (pc),
    .next_pc    (next_pc),
    .takb       (takb)
  );

endmodule

// File: tests/btb_fetch_properties.sv
// concurrent checks on the fetch predictor top level, bound into btb_fetch_top

`timescale 1ns/1ps

module btb_fetch_properties import fetch_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     advance,
  input logic     irq,
  input logic     do_ret,
  input logic     branchmiss,
  input logic     takb,
  input pc_addr_t pc
);

  // ==================================================
  // pc and prediction rules
  // ==================================================

  // stall freezes the program counter
  hold_pc_on_stall: assert property (
    @(posedge clk) disable iff (rst) !advance |=> pc == $past(pc)
  ) else $error("pc changed on an edge where advance was low");

  // any redirect outranks the BTB
  no_takb_on_redirect: assert property (
    @(posedge clk) disable iff (rst) !(takb && (irq || do_ret || branchmiss))
  ) else $error("takb high together with irq, do_ret or branchmiss");

  pc_after_reset: assert property (
    @(posedge clk) rst |=> pc == RST_PC
  ) else $error("pc is not the reset vector after reset");

endmodule

bind btb_fetch_top btb_fetch_properties btb_fetch_properties_i (
  .clk        (clk),
  .rst        (rst),
  .advance    (advance),
  .irq        (irq),
  .do_ret     (do_ret),
  .branchmiss (branchmiss),
  .takb       (takb),
  .pc         (pc)
);

// File: tests/btb_fetch_tb.sv
// random-stimulus testbench for the fetch predictor, checks pc, next_pc and takb every cycle

`timescale 1ns/1ps

module btb_fetch_tb import fetch_pkg::*, btb_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RST_CYCLES   = 8;
  localparam int N_CYCLES     = 3000;
  localparam int QUIET_CYCLES = 20;               // plain sequential fetch at the start

  logic     clk;
  logic     rst;
  logic     advance;
  logic     irq;
  logic     do_call;
  logic     do_ret;
  logic     branchmiss;
  logic     commit_valid;
  logic     commit_takb;
  pc_addr_t irq_addr;
  pc_addr_t ret_pc;
  pc_addr_t misspc;
  pc_addr_t commit_pc;
  pc_addr_t commit_tgt;
  pc_addr_t pc;
  pc_addr_t next_pc;
  logic     takb;

  int seed    = 2;
  int err_cnt = 0;
  int chk_cnt = 0;
  int hit_cnt = 0;                                // predicted-taken cycles seen

  // ==================================================
  // reference model state
  // ==================================================

  pc_addr_t m_pc;
  pc_addr_t ras_model [$];                        // newest at the back
  bit       tbl_takb [int];                       // table keyed by slot
  pc_addr_t tbl_tag [int];
  pc_addr_t tbl_tgt [int];
  bit       rd_takb;                              // entry read for the current pc
  pc_addr_t rd_tag;
  pc_addr_t rd_tgt;
  bit       pend_valid;                           // commit waiting one edge for the write
  int       pend_slot;
  bit       pend_takb;
  pc_addr_t pend_pc;
  pc_addr_t pend_tgt;
  pc_addr_t exp_next;
  bit       exp_takb;

  btb_fetch_top btb_fetch_top_i (
    .clk          (clk),
    .rst          (rst),
    .advance      (advance),
    .irq          (irq),
    .irq_addr     (irq_addr),
    .do_call      (do_call),
    .ret_pc       (ret_pc),
    .do_ret       (do_ret),
    .branchmiss   (branchmiss),
    .misspc       (misspc),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_takb  (commit_takb),
    .commit_tgt   (commit_tgt),
    .pc           (pc),
    .next_pc      (next_pc),
    .takb         (takb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // address of fetch group k counted from the reset vector
  function automatic pc_addr_t group_addr(input int k);
    return RST_PC + FETCH_BYTES * pc_addr_t'(k);
  endfunction

  function automatic int slot_of(input pc_addr_t a);
    return int'((a >> 1) & 32'h0000_03FF);        // address bits 10:1
  endfunction

  function automatic bit roll(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  task automatic drive_inputs(input bit quiet);
    advance      = quiet ? 1'b1 : roll(85);
    irq          = quiet ? 1'b0 : roll(3);
    do_ret       = quiet ? 1'b0 : (roll(6) && ras_model.size() != 0);   // never underflow
    do_call      = quiet ? 1'b0 : (roll(7) && (do_ret || ras_model.size() < RAS_DEPTH));
    branchmiss   = quiet ? 1'b0 : roll(4);
    irq_addr     = group_addr(pick(32));          // redirects land where commits train
    misspc       = group_addr(pick(32));
    ret_pc       = group_addr(pick(48));
    commit_valid = quiet ? 1'b0 : roll(30);
    commit_pc    = group_addr(pick(32));
    commit_tgt   = group_addr(pick(32));
    commit_takb  = roll(75);                      // some not-taken commits clear entries
  endtask

  // expected outputs by the priority rule, checked mid cycle
  task automatic check_outputs();
    exp_takb = 1'b0;
    if (irq) begin
      exp_next = irq_addr;
    end else if (do_ret) begin
      exp_next = ras_model[$];
    end else if (branchmiss) begin
      exp_next = misspc;
    end else if (rd_takb && rd_tag == m_pc) begin
      exp_next = rd_tgt;
      exp_takb = 1'b1;
      hit_cnt++;
    end else begin
      exp_next = m_pc + FETCH_BYTES;
    end
    compare_value(pc, m_pc, "pc");
    compare_value(next_pc, exp_next, "next_pc");
    compare_value(takb, exp_takb, "takb");
  endtask

  // model update at the rising edge
  task automatic advance_model();
    pc_addr_t new_pc;
    int       slot;
    new_pc = advance ? exp_next : m_pc;           // stall holds pc and rereads its slot
    slot   = slot_of(new_pc);
    if (tbl_tag.exists(slot)) begin               // read before this edge's write
      rd_takb = tbl_takb[slot];
      rd_tag  = tbl_tag[slot];
      rd_tgt  = tbl_tgt[slot];
    end else begin
      rd_takb = 1'b0;
      rd_tag  = '0;
      rd_tgt  = '0;
    end
    if (pend_valid) begin
      tbl_takb[pend_slot] = pend_takb;
      tbl_tag[pend_slot]  = pend_pc;
      tbl_tgt[pend_slot]  = pend_tgt;
    end
    pend_valid = commit_valid;
    pend_slot  = slot_of(commit_pc);
    pend_takb  = commit_takb;
    pend_pc    = commit_pc;
    pend_tgt   = commit_tgt;
    if (advance) begin
      if (do_call && !do_ret) begin
        ras_model.push_back(ret_pc);
      end else if (do_ret && !do_call) begin
        void'(ras_model.pop_back());
      end
    end
    m_pc = new_pc;
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================

  initial begin
    rst          = 1'b1;
    advance      = 1'b0;
    irq          = 1'b0;
    do_call      = 1'b0;
    do_ret       = 1'b0;
    branchmiss   = 1'b0;
    commit_valid = 1'b0;
    commit_takb  = 1'b0;
    irq_addr     = '0;
    ret_pc       = '0;
    misspc       = '0;
    commit_pc    = '0;
    commit_tgt   = '0;
    m_pc         = RST_PC;
    rd_takb      = 1'b0;
    rd_tag       = '0;
    rd_tgt       = '0;
    pend_valid   = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < N_CYCLES; i++) begin
      drive_inputs(i < QUIET_CYCLES);
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      advance_model();
      #1;
    end
    compare_value(hit_cnt != 0, 1, "BTB predicted at least once");
    $display("checks %0d, errors %0d, taken predictions %0d", chk_cnt, err_cnt, hit_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #((RST_CYCLES + N_CYCLES + 100) * CLK_PERIOD);
    $display("timeout, the test loop did not finish in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: flist.f
verilog/fetch_pkg.sv
verilog/btb_pkg.sv
verilog/btb_ifs.sv
verilog/btb_commit_stage.sv
verilog/btb_lookup_stage.sv
verilog/return_stack.sv
verilog/pc_select_stage.sv
verilog/btb_fetch_top.sv
tests/btb_fetch_properties.sv
tests/btb_fetch_tb.sv

// File: Makefile
TOP := btb_fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf obj_dir
